// ==== include/trace_params.svh ====
//////////////////////////////////////////////////////////////////////
// trace monitor build constants
// data/address width, record FIFO depth and configuration map
// include wherever a width, depth or register address is needed
//////////////////////////////////////////////////////////////////////

`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// bus data and address width
`define TRACE_XLEN 32

// record FIFO
`define TRACE_FIFO_DEPTH 8
`define TRACE_LVL_W ($clog2(`TRACE_FIFO_DEPTH + 1))  // fill level width

// configuration register map
`define TRACE_CFG_AW     2  // cfg address width
`define TRACE_CFG_CTRL   0  // enable, memory-only filter
`define TRACE_CFG_STATUS 1  // overflow, full, level

// status register bit positions
`define TRACE_STS_OVF  0  // sticky overflow, write 1 to clear
`define TRACE_STS_FULL 1
`define TRACE_STS_LVL  8  // fill level field lsb

`endif

// ==== design/trace_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the execution trace monitor
// bus request, phase codes, retired instruction record and control
// referenced by scoped names from the monitor, cfg block and FIFO
//////////////////////////////////////////////////////////////////////

`include "trace_params.svh"

package trace_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus side
    //////////////////////////////////////////////////////////////////////

    // core FSM phase of a bus transfer
    // GPR phases have the top bit set
    typedef enum logic [2:0] {
        IF  = 3'b000,  // instruction fetch
        MLD = 3'b001,  // memory load
        MST = 3'b010,  // memory store
        EXE = 3'b011,  // branch condition, no bus data
        WB  = 3'b100,  // GPR write-back
        RS1 = 3'b101,  // GPR read rs1
        RS2 = 3'b110   // GPR read rs2
    } pha_e;

    // register file view of the address word
    typedef struct packed {
        logic [`TRACE_XLEN-8:0] rsv;  // unused upper bits
        logic [4:0]             idx;  // GPR index
        logic [1:0]             byt;  // word aligned, always 0
    } gpr_adr_t;

    // one address word, decoded by phase
    typedef union packed {
        logic [`TRACE_XLEN-1:0] mem;  // memory / fetch address
        gpr_adr_t               gpr;  // register file phases
    } bus_adr_u;

    // request part of a transfer
    typedef struct packed {
        bus_adr_u               adr;
        logic [`TRACE_XLEN-1:0] wdt;  // write data
        logic                   wen;  // write enable
        logic [1:0]             siz;  // log2 of byte count
    } bus_req_t;

    //////////////////////////////////////////////////////////////////////
    // record side
    //////////////////////////////////////////////////////////////////////

    // one retired instruction
    typedef struct packed {
        logic [`TRACE_XLEN-1:0] ifu_adr;  // PC
        logic [`TRACE_XLEN-1:0] ifu_ins;  // instruction word
        logic                   wbu_ena;  // GPR written
        logic [4:0]             wbu_idx;
        logic [`TRACE_XLEN-1:0] wbu_dat;
        logic                   lsu_ena;  // memory accessed
        logic                   lsu_wen;  // 1 store, 0 load
        logic [`TRACE_XLEN-1:0] lsu_adr;
        logic [1:0]             lsu_siz;
        logic [`TRACE_XLEN-1:0] lsu_dat;  // load or store data
    } trace_rec_t;

    // control register, ena in bit 0
    typedef struct packed {
        logic mem_only;  // keep load/store records only
        logic ena;       // record enable
    } cfg_ctrl_t;

endpackage

// ==== design/trace_monitor.sv ====
//////////////////////////////////////////////////////////////////////
// bus trace monitor
// watches the shared fetch/GPR/memory bus of the core and builds one
// record per retired instruction, closed by the next fetch
// closed records are pushed into the record FIFO when enabled
//////////////////////////////////////////////////////////////////////

`include "trace_params.svh"

module trace_monitor (
    input  logic                   tcb,
    input  logic                   rst_n,
    // core bus
    input  logic                   bus_trn,   // transfer strobe
    input  trace_pkg::pha_e        bus_pha,
    input  trace_pkg::bus_req_t    bus_req,
    input  logic [`TRACE_XLEN-1:0] bus_rdt,   // one cycle after bus_trn
    // control and FIFO state
    input  trace_pkg::cfg_ctrl_t   ctrl,
    input  logic                   full,
    // record output
    output logic                   rec_push,
    output trace_pkg::trace_rec_t  rec_in,
    output logic                   drop       // record lost on full FIFO
);

    //////////////////////////////////////////////////////////////////////
    // request delay, pairs read data with its request
    //////////////////////////////////////////////////////////////////////

    logic                trn_q;
    trace_pkg::pha_e     pha_q;
    trace_pkg::bus_req_t req_q;

    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            trn_q <= 1'b0;
        end else begin
            trn_q <= bus_trn;
        end
    end

    always_ff @(posedge tcb) begin
        pha_q <= bus_pha;
        req_q <= bus_req;
    end

    //////////////////////////////////////////////////////////////////////
    // open record
    //////////////////////////////////////////////////////////////////////

    logic                   opn;      // a fetch has been seen
    logic                   wbu_ena;
    logic                   lsu_ena;
    logic [`TRACE_XLEN-1:0] ifu_adr;
    logic [`TRACE_XLEN-1:0] ifu_ins;
    logic [4:0]             wbu_idx;
    logic [`TRACE_XLEN-1:0] wbu_dat;
    logic                   lsu_wen;
    logic [`TRACE_XLEN-1:0] lsu_adr;
    logic [1:0]             lsu_siz;
    logic [`TRACE_XLEN-1:0] lsu_dat;

    // valid bits
    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            opn     <= 1'b0;
            wbu_ena <= 1'b0;
            lsu_ena <= 1'b0;
        end else if (trn_q) begin
            case (pha_q)
                trace_pkg::IF: begin
                    opn     <= 1'b1;
                    wbu_ena <= 1'b0;  // new instruction starts empty
                    lsu_ena <= 1'b0;
                end
                trace_pkg::WB:  wbu_ena <= 1'b1;
                trace_pkg::MLD: lsu_ena <= 1'b1;
                trace_pkg::MST: lsu_ena <= 1'b1;
                default: ;  // RS1, RS2, EXE not traced
            endcase
        end
    end

    // record payload, unused parts zeroed on fetch
    always_ff @(posedge tcb) begin
        if (trn_q) begin
            case (pha_q)
                trace_pkg::IF: begin
                    ifu_adr <= req_q.adr.mem;
                    ifu_ins <= bus_rdt;  // instruction word
                    wbu_idx <= '0;
                    wbu_dat <= '0;
                    lsu_wen <= 1'b0;
                    lsu_adr <= '0;
                    lsu_siz <= '0;
                    lsu_dat <= '0;
                end
                trace_pkg::WB: begin
                    wbu_idx <= req_q.adr.gpr.idx;  // GPR view of address
                    wbu_dat <= req_q.wdt;
                end
                trace_pkg::MLD: begin
                    lsu_wen <= 1'b0;
                    lsu_adr <= req_q.adr.mem;
                    lsu_siz <= req_q.siz;
                    lsu_dat <= bus_rdt;    // load data arrives now
                end
                trace_pkg::MST: begin
                    lsu_wen <= 1'b1;
                    lsu_adr <= req_q.adr.mem;
                    lsu_siz <= req_q.siz;
                    lsu_dat <= req_q.wdt;  // store data
                end
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // record close and push
    //////////////////////////////////////////////////////////////////////

    logic rec_cls;  // fetch closes the open record
    logic rec_keep; // record passes enable and filter

    assign rec_cls  = trn_q && (pha_q == trace_pkg::IF) && opn;
    assign rec_keep = ctrl.ena && (!ctrl.mem_only || lsu_ena);

    assign rec_push = rec_cls && rec_keep && !full;
    assign drop     = rec_cls && rec_keep &&  full;

    always_comb begin
        rec_in.ifu_adr = ifu_adr;
        rec_in.ifu_ins = ifu_ins;
        rec_in.wbu_ena = wbu_ena;
        rec_in.wbu_idx = wbu_idx;
        rec_in.wbu_dat = wbu_dat;
        rec_in.lsu_ena = lsu_ena;
        rec_in.lsu_wen = lsu_wen;
        rec_in.lsu_adr = lsu_adr;
        rec_in.lsu_siz = lsu_siz;
        rec_in.lsu_dat = lsu_dat;
    end

    // core only issues the seven defined phases
    a_pha_legal: assert property (@(posedge tcb) disable iff (!rst_n)
        bus_trn |-> bus_pha inside {trace_pkg::IF, trace_pkg::RS1, trace_pkg::RS2,
                                    trace_pkg::MLD, trace_pkg::MST, trace_pkg::EXE,
                                    trace_pkg::WB});

    // stores are write transfers
    a_mst_wen: assert property (@(posedge tcb) disable iff (!rst_n)
        (bus_trn && bus_pha == trace_pkg::MST) |-> bus_req.wen);

endmodule

// ==== design/trace_cfg.sv ====
//////////////////////////////////////////////////////////////////////
// trace configuration and status registers
// CTRL holds enable and the memory-only filter for the monitor
// STATUS reports sticky overflow, FIFO full and fill level
// writes take effect at the clock edge, reads are combinational
//////////////////////////////////////////////////////////////////////

`include "trace_params.svh"

module trace_cfg (
    input  logic                    tcb,
    input  logic                    rst_n,
    // register access
    input  logic                    cfg_wen,
    input  logic [`TRACE_CFG_AW-1:0] cfg_adr,
    input  logic [`TRACE_XLEN-1:0]  cfg_wdt,
    output logic [`TRACE_XLEN-1:0]  cfg_rdt,
    // monitor and FIFO
    output trace_pkg::cfg_ctrl_t    ctrl,
    input  logic                    drop,
    input  logic                    full,
    input  logic [`TRACE_LVL_W-1:0] level
);

    localparam int unsigned CW = $bits(trace_pkg::cfg_ctrl_t);

    logic ovf;      // sticky overflow
    logic wen_ctl;  // CTRL write
    logic wen_sts;  // STATUS write

    assign wen_ctl = cfg_wen && (cfg_adr == `TRACE_CFG_CTRL);
    assign wen_sts = cfg_wen && (cfg_adr == `TRACE_CFG_STATUS);

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;  // tracing off, no filter
        end else if (wen_ctl) begin
            ctrl <= cfg_wdt[CW-1:0];
        end
    end

    // new drop wins over a clear in the same cycle
    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            ovf <= 1'b0;
        end else if (drop) begin
            ovf <= 1'b1;
        end else if (wen_sts && cfg_wdt[`TRACE_STS_OVF]) begin
            ovf <= 1'b0;  // write 1 to clear
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cfg_rdt = '0;  // unmapped addresses read 0
        case (cfg_adr)
            `TRACE_CFG_CTRL: cfg_rdt[CW-1:0] = ctrl;
            `TRACE_CFG_STATUS: begin
                cfg_rdt[`TRACE_STS_OVF]                  = ovf;
                cfg_rdt[`TRACE_STS_FULL]                 = full;
                cfg_rdt[`TRACE_STS_LVL +: `TRACE_LVL_W]  = level;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/trace_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// trace record FIFO
// circular buffer between the monitor and the host
// push and pop are one-cycle strobes, rec shows the oldest entry
// push while full and pop while empty are ignored
//////////////////////////////////////////////////////////////////////

`include "trace_params.svh"

module trace_fifo (
    input  logic                    tcb,
    input  logic                    rst_n,
    // write side
    input  logic                    rec_push,
    input  trace_pkg::trace_rec_t   rec_in,
    // read side
    input  logic                    rec_pop,
    output trace_pkg::trace_rec_t   rec,
    output logic                    rec_vld,
    // status
    output logic                    full,
    output logic [`TRACE_LVL_W-1:0] level
);

    localparam int unsigned DEPTH = `TRACE_FIFO_DEPTH;
    localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned LW    = `TRACE_LVL_W;

    trace_pkg::trace_rec_t mem [DEPTH];  // record storage
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [LW-1:0]         cnt;
    logic                  do_push;
    logic                  do_pop;

    // pointer increment with wrap at DEPTH
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = rec_push && !full;
    assign do_pop  = rec_pop  && rec_vld;

    always_ff @(posedge tcb) begin
        if (do_push) begin
            mem[wr_ptr] <= rec_in;
        end
    end

    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: ;  // both or neither, count holds
            endcase
        end
    end

    assign rec     = mem[rd_ptr];  // oldest record
    assign rec_vld = (cnt != '0);
    assign full    = (cnt == LW'(DEPTH));
    assign level   = cnt;

    // monitor drops records itself when full
    a_no_push_full: assert property (@(posedge tcb) disable iff (!rst_n)
        rec_push |-> !full);

endmodule

// ==== design/trace_top.sv ====
//////////////////////////////////////////////////////////////////////
// execution trace subsystem top
// monitor on the core bus, config/status registers and record FIFO
// host reads records through rec/rec_vld and pops with rec_pop
//////////////////////////////////////////////////////////////////////

`include "trace_params.svh"

module trace_top (
    input  logic                     tcb,
    input  logic                     rst_n,
    // core bus
    input  logic                     bus_trn,
    input  trace_pkg::pha_e          bus_pha,
    input  trace_pkg::bus_req_t      bus_req,
    input  logic [`TRACE_XLEN-1:0]   bus_rdt,
    // configuration
    input  logic                     cfg_wen,
    input  logic [`TRACE_CFG_AW-1:0] cfg_adr,
    input  logic [`TRACE_XLEN-1:0]   cfg_wdt,
    output logic [`TRACE_XLEN-1:0]   cfg_rdt,
    // records
    input  logic                     rec_pop,
    output trace_pkg::trace_rec_t    rec,
    output logic                     rec_vld
);

    logic                    rec_push;
    trace_pkg::trace_rec_t   rec_in;
    logic                    drop;
    logic                    full;
    logic [`TRACE_LVL_W-1:0] level;
    trace_pkg::cfg_ctrl_t    ctrl;

    trace_monitor i_monitor (
        .tcb      (tcb),
        .rst_n    (rst_n),
        .bus_trn  (bus_trn),
        .bus_pha  (bus_pha),
        .bus_req  (bus_req),
        .bus_rdt  (bus_rdt),
        .ctrl     (ctrl),
        .full     (full),
        .rec_push (rec_push),
        .rec_in   (rec_in),
        .drop     (drop)
    );

    trace_cfg i_cfg (
        .tcb     (tcb),
        .rst_n   (rst_n),
        .cfg_wen (cfg_wen),
        .cfg_adr (cfg_adr),
        .cfg_wdt (cfg_wdt),
        .cfg_rdt (cfg_rdt),
        .ctrl    (ctrl),
        .drop    (drop),
        .full    (full),
        .level   (level)
    );

    trace_fifo i_fifo (
        .tcb      (tcb),
        .rst_n    (rst_n),
        .rec_push (rec_push),
        .rec_in   (rec_in),
        .rec_pop  (rec_pop),
        .rec      (rec),
        .rec_vld  (rec_vld),
        .full     (full),
        .level    (level)
    );

endmodule

// ==== tests/trace_tb.sv ====
//////////////////////////////////////////////////////////////////////
// directed testbench for the execution trace subsystem
// drives fetch, GPR and memory transfers on the core bus, keeps a
// software record model and pops records through the host side
//////////////////////////////////////////////////////////////////////

`include "trace_params.svh"

module trace_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 2000;  // about 4x the total test length
    localparam int DEPTH       = `TRACE_FIFO_DEPTH;

    logic                     tcb;
    logic                     rst_n;
    logic                     bus_trn;
    trace_pkg::pha_e          bus_pha;
    trace_pkg::bus_req_t      bus_req;
    logic [`TRACE_XLEN-1:0]   bus_rdt;
    logic                     cfg_wen;
    logic [`TRACE_CFG_AW-1:0] cfg_adr;
    logic [`TRACE_XLEN-1:0]   cfg_wdt;
    logic [`TRACE_XLEN-1:0]   cfg_rdt;
    logic                     rec_pop;
    trace_pkg::trace_rec_t    rec;
    logic                     rec_vld;

    // reference model state
    trace_pkg::trace_rec_t exp_q[$];  // records expected in the FIFO
    trace_pkg::trace_rec_t opn_rec;   // instruction being built
    logic                  opn_vld;
    trace_pkg::cfg_ctrl_t  ctrl_mdl;
    logic                  ovf_mdl;

    integer seed = 32'h9e06;
    int     cycles;
    int     checks;
    int     errors;
    int     test_err;
    int     tests;
    string  test_name;

    trace_top i_dut (
        .tcb     (tcb),
        .rst_n   (rst_n),
        .bus_trn (bus_trn),
        .bus_pha (bus_pha),
        .bus_req (bus_req),
        .bus_rdt (bus_rdt),
        .cfg_wen (cfg_wen),
        .cfg_adr (cfg_adr),
        .cfg_wdt (cfg_wdt),
        .cfg_rdt (cfg_rdt),
        .rec_pop (rec_pop),
        .rec     (rec),
        .rec_vld (rec_vld)
    );

    initial begin
        tcb = 1'b0;
        forever #5 tcb = ~tcb;
    end

    always @(posedge tcb) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped at the cycle limit of %0d", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_rec(input string name, input trace_pkg::trace_rec_t exp,
                             input trace_pkg::trace_rec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [`TRACE_XLEN-1:0] exp,
                              input logic [`TRACE_XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // single-bit host flags
    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b actual %b", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus stimulus and record model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`TRACE_XLEN-1:0] rnd_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rnd_idx();
        logic [`TRACE_XLEN-1:0] w;
        w = $random(seed);
        return w[4:0];
    endfunction

    function automatic logic [1:0] rnd_siz();
        logic [`TRACE_XLEN-1:0] w;
        w = $random(seed);
        return w[1:0];
    endfunction

    function automatic trace_pkg::bus_req_t mem_req(input logic [`TRACE_XLEN-1:0] adr,
                                                   input logic [`TRACE_XLEN-1:0] wdt,
                                                   input logic wen, input logic [1:0] siz);
        trace_pkg::bus_req_t req;
        req.adr.mem = adr;
        req.wdt     = wdt;
        req.wen     = wen;
        req.siz     = siz;
        return req;
    endfunction

    // register file address, index in bits 6..2
    function automatic trace_pkg::bus_req_t gpr_req(input logic [4:0] idx,
                                                   input logic [`TRACE_XLEN-1:0] wdt,
                                                   input logic wen);
        trace_pkg::bus_req_t req;
        req             = '0;
        req.adr.gpr.idx = idx;
        req.wdt         = wdt;
        req.wen         = wen;
        req.siz         = 2'd2;
        return req;
    endfunction

    // one transfer, read data in the following cycle
    task automatic xfer(input trace_pkg::pha_e pha, input trace_pkg::bus_req_t req,
                        input logic [`TRACE_XLEN-1:0] rdt);
        @(posedge tcb);
        bus_trn <= 1'b1;
        bus_pha <= pha;
        bus_req <= req;
        @(posedge tcb);
        bus_trn <= 1'b0;
        bus_rdt <= rdt;
    endtask

    // fetch closes the open record in the model
    task automatic fetch(input logic [`TRACE_XLEN-1:0] pc, input logic [`TRACE_XLEN-1:0] ins);
        if (opn_vld && ctrl_mdl.ena && (!ctrl_mdl.mem_only || opn_rec.lsu_ena)) begin
            if (exp_q.size() < DEPTH) exp_q.push_back(opn_rec);
            else ovf_mdl = 1'b1;  // lost, FIFO full
        end
        opn_rec         = '0;
        opn_rec.ifu_adr = pc;
        opn_rec.ifu_ins = ins;
        opn_vld         = 1'b1;
        xfer(trace_pkg::IF, mem_req(pc, '0, 1'b0, 2'd2), ins);
    endtask

    // register reads carry random data that must not reach a record
    task automatic reg_read(input trace_pkg::pha_e pha);
        xfer(pha, gpr_req(rnd_idx(), rnd_word(), 1'b0), rnd_word());
    endtask

    task automatic write_back(input logic [4:0] idx, input logic [`TRACE_XLEN-1:0] dat);
        opn_rec.wbu_ena = 1'b1;
        opn_rec.wbu_idx = idx;
        opn_rec.wbu_dat = dat;
        xfer(trace_pkg::WB, gpr_req(idx, dat, 1'b1), rnd_word());
    endtask

    task automatic mem_access(input logic st, input logic [`TRACE_XLEN-1:0] adr,
                              input logic [1:0] siz, input logic [`TRACE_XLEN-1:0] dat);
        opn_rec.lsu_ena = 1'b1;
        opn_rec.lsu_wen = st;
        opn_rec.lsu_adr = adr;
        opn_rec.lsu_siz = siz;
        opn_rec.lsu_dat = dat;  // store data or load data
        if (st) xfer(trace_pkg::MST, mem_req(adr, dat, 1'b1, siz), rnd_word());
        else    xfer(trace_pkg::MLD, mem_req(adr, rnd_word(), 1'b0, siz), dat);
    endtask

    task automatic alu_insn();
        fetch(rnd_word() & ~32'h3, rnd_word());
        reg_read(trace_pkg::RS1);
        reg_read(trace_pkg::RS2);
        xfer(trace_pkg::EXE, gpr_req(5'd0, '0, 1'b0), rnd_word());  // no bus data
        write_back(rnd_idx(), rnd_word());
    endtask

    task automatic load_insn();
        logic [`TRACE_XLEN-1:0] dat;
        dat = rnd_word();
        fetch(rnd_word() & ~32'h3, rnd_word());
        reg_read(trace_pkg::RS1);
        mem_access(1'b0, rnd_word(), rnd_siz(), dat);
        write_back(rnd_idx(), dat);
    endtask

    task automatic store_insn();
        fetch(rnd_word() & ~32'h3, rnd_word());
        reg_read(trace_pkg::RS1);
        reg_read(trace_pkg::RS2);
        mem_access(1'b1, rnd_word(), rnd_siz(), rnd_word());
    endtask

    //////////////////////////////////////////////////////////////////////
    // config and host side
    //////////////////////////////////////////////////////////////////////

    task automatic cfg_write(input logic [`TRACE_CFG_AW-1:0] adr,
                             input logic [`TRACE_XLEN-1:0] dat);
        if (adr == `TRACE_CFG_CTRL) ctrl_mdl = dat[$bits(trace_pkg::cfg_ctrl_t)-1:0];
        if (adr == `TRACE_CFG_STATUS && dat[`TRACE_STS_OVF]) ovf_mdl = 1'b0;
        @(posedge tcb);
        cfg_wen <= 1'b1;
        cfg_adr <= adr;
        cfg_wdt <= dat;
        @(posedge tcb);
        cfg_wen <= 1'b0;
    endtask

    task automatic cfg_check(input logic [`TRACE_CFG_AW-1:0] adr,
                             input logic [`TRACE_XLEN-1:0] exp);
        @(posedge tcb);
        cfg_adr <= adr;
        @(negedge tcb);  // combinational read settled
        check_word(test_name, exp, cfg_rdt);
    endtask

    // overflow, full and level as the model sees them
    task automatic status_check();
        logic [`TRACE_XLEN-1:0] w;
        w                                 = '0;
        w[`TRACE_STS_OVF]                 = ovf_mdl;
        w[`TRACE_STS_FULL]                = (exp_q.size() == DEPTH);
        w[`TRACE_STS_LVL +: `TRACE_LVL_W] = exp_q.size();
        cfg_check(`TRACE_CFG_STATUS, w);
        check_flag(test_name, exp_q.size() != 0, rec_vld);  // same negedge as the read
    endtask

    task automatic pop_record();
        int wait_cyc;
        wait_cyc = 0;
        @(negedge tcb);
        while (!rec_vld && wait_cyc < 8) begin
            @(negedge tcb);
            wait_cyc++;
        end
        if (rec_vld) begin
            check_rec(test_name, exp_q[0], rec);
            @(posedge tcb);
            rec_pop <= 1'b1;
            @(posedge tcb);
            rec_pop <= 1'b0;
        end else begin
            errors++;
            $display("%s: record expected but the FIFO stayed empty", test_name);
        end
        void'(exp_q.pop_front());
    endtask

    task automatic drain();
        while (exp_q.size() > 0) pop_record();
        status_check();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_err) $display("%s: ok", test_name);
        else $display("%s: %0d errors", test_name, errors - test_err);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        bus_trn  = 1'b0;
        bus_pha  = trace_pkg::IF;
        bus_req  = '0;
        bus_rdt  = '0;
        cfg_wen  = 1'b0;
        cfg_adr  = '0;
        cfg_wdt  = '0;
        rec_pop  = 1'b0;
        rst_n    = 1'b0;
        opn_rec  = '0;
        opn_vld  = 1'b0;
        ctrl_mdl = '0;
        ovf_mdl  = 1'b0;
        cycles   = 0;
        checks   = 0;
        errors   = 0;
        tests    = 0;
        repeat (10) @(posedge tcb);
        rst_n <= 1'b1;

        start_test("alu_record");
        cfg_write(`TRACE_CFG_CTRL, 32'h1);
        alu_insn();
        status_check();  // first fetch closes nothing
        alu_insn();
        drain();
        end_test();

        start_test("load_store_record");
        load_insn();
        store_insn();
        alu_insn();
        drain();
        end_test();

        start_test("mem_only_filter");
        cfg_write(`TRACE_CFG_CTRL, 32'h3);
        alu_insn();
        load_insn();
        alu_insn();
        store_insn();
        alu_insn();
        load_insn();
        alu_insn();
        drain();
        end_test();

        start_test("enable_off");
        cfg_write(`TRACE_CFG_CTRL, 32'h0);
        alu_insn();
        load_insn();
        store_insn();
        status_check();
        cfg_write(`TRACE_CFG_CTRL, 32'h1);
        alu_insn();  // closes the store, now enabled
        load_insn();
        alu_insn();
        drain();
        end_test();

        start_test("overflow");
        for (int i = 0; i < DEPTH + 2; i++) alu_insn();
        status_check();  // overflow and full
        drain();
        cfg_write(`TRACE_CFG_STATUS, 32'h1 << `TRACE_STS_OVF);
        status_check();
        end_test();

        start_test("cfg_regs");
        cfg_write(`TRACE_CFG_CTRL, 32'h2);
        cfg_check(`TRACE_CFG_CTRL, 32'h2);
        cfg_write(`TRACE_CFG_CTRL, 32'h3);
        cfg_check(`TRACE_CFG_CTRL, 32'h3);
        cfg_write(`TRACE_CFG_CTRL, 32'h1);
        cfg_check(`TRACE_CFG_CTRL, 32'h1);
        repeat (3) alu_insn();
        status_check();
        pop_record();
        status_check();  // level one lower
        drain();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
design/trace_pkg.sv
design/trace_monitor.sv
design/trace_cfg.sv
design/trace_fifo.sv
design/trace_top.sv
tests/trace_tb.sv

// ==== Bender.yml ====
package:
  name: trace_monitor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/trace_pkg.sv
      - design/trace_monitor.sv
      - design/trace_cfg.sv
      - design/trace_fifo.sv
      - design/trace_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/trace_tb.sv
